/* verilog/mem_pkg.sv */
package mem_pkg;

	// command carried on every request path
	typedef enum logic [1:0]
	{
		bus_none  = 2'b00,
		bus_load  = 2'b01,
		bus_store = 2'b10
	} bus_command;

	// address and block geometry
	localparam int ADDR_BITS    = 64;
	localparam int BLOCK_BITS   = 64;
	localparam int BLOCK_OFFSET = 3;

	// dcache: 32 direct-mapped lines
	localparam int DCACHE_INDEX_BITS = 5;
	localparam int DCACHE_TAG_BITS   = ADDR_BITS - DCACHE_INDEX_BITS - BLOCK_OFFSET;

	// icache: 16 direct-mapped lines
	localparam int ICACHE_INDEX_BITS = 4;
	localparam int ICACHE_TAG_BITS   = ADDR_BITS - ICACHE_INDEX_BITS - BLOCK_OFFSET;

	// memory tags, zero means no tag
	localparam int TAG_BITS = 4;

	// cycles from acceptance to tag return
	localparam int MEM_LATENCY = 8;

	// backing store size, block addresses wrap
	localparam int MEM_BLOCKS     = 4096;
	localparam int MEM_INDEX_BITS = $clog2(MEM_BLOCKS);

	// outstanding dcache misses
	localparam int MSHR_ENTRIES   = 4;
	localparam int MSHR_SLOT_BITS = $clog2(MSHR_ENTRIES);

endpackage

/* verilog/dcache_controller.sv */
`timescale 1ns/10ps

module dcache_controller
(
	// from the processor
	input  mem_pkg::bus_command                     proc2dcache_command,
	input  logic [mem_pkg::ADDR_BITS-1:0]           proc2dcache_addr,
	input  logic [mem_pkg::BLOCK_BITS-1:0]          proc2dcache_data,

	// from the memory side
	input  logic [mem_pkg::TAG_BITS-1:0]            mem_response,
	input  logic [mem_pkg::TAG_BITS-1:0]            mem_tag,

	// from the cache arrays
	input  logic [mem_pkg::BLOCK_BITS-1:0]          cachemem_data,
	input  logic                                    cachemem_valid,
	input  logic                                    cachemem_dirty,
	input  logic                                    cachemem_miss,
	input  logic                                    cachemem_full,
	input  logic [mem_pkg::ADDR_BITS-1:0]           cachemem_victim_addr,

	// to the cache arrays
	output logic [mem_pkg::DCACHE_INDEX_BITS-1:0]   dcache_index,
	output logic [mem_pkg::DCACHE_TAG_BITS-1:0]     dcache_tag,
	output logic                                    read_enable,
	output logic                                    write_enable,
	output logic [mem_pkg::BLOCK_BITS-1:0]          write_data,

	// to the memory bus
	output mem_pkg::bus_command                     dmem_command,
	output logic [mem_pkg::ADDR_BITS-1:0]           dmem_addr,
	output logic [mem_pkg::BLOCK_BITS-1:0]          dmem_data,

	// to the processor
	output logic [mem_pkg::BLOCK_BITS-1:0]          dcache_data_out,
	output logic                                    dcache_data_hit,
	output logic [mem_pkg::TAG_BITS-1:0]            dcache2proc_response,
	output logic [mem_pkg::TAG_BITS-1:0]            dcache2proc_tag
);

	import mem_pkg::*;

	logic fill_busy;
	logic victim_dirty;

	assign {dcache_tag, dcache_index} = proc2dcache_addr[ADDR_BITS-1:BLOCK_OFFSET];
	assign write_data                 = proc2dcache_data;

	// a returning fill owns the data path this cycle
	assign fill_busy       = (mem_tag != '0);
	assign dcache_data_out = cachemem_data;
	assign dcache2proc_tag = mem_tag;

	assign victim_dirty = cachemem_valid && cachemem_dirty;

	always_comb
	begin
		read_enable          = 1'b0;
		write_enable         = 1'b0;
		dmem_command         = bus_none;
		dmem_addr            = '0;
		dmem_data            = '0;
		dcache_data_hit      = 1'b0;
		dcache2proc_response = '0;
		case (proc2dcache_command)
			bus_load,
			bus_store:
			begin
				read_enable = 1'b1;
				if (fill_busy)
				begin
					// processor sees hit low, response zero and retries
				end
				else if (!cachemem_miss)
				begin
					dcache_data_hit = 1'b1;
					write_enable    = (proc2dcache_command == bus_store);
				end
				else if (!cachemem_full)
				begin
					if (victim_dirty)
					begin
						// write the old block back first, no miss started yet
						dmem_command = bus_store;
						dmem_addr    = cachemem_victim_addr;
						dmem_data    = cachemem_data;
					end
					else
					begin
						dmem_command         = bus_load;
						dmem_addr            = {proc2dcache_addr[ADDR_BITS-1:BLOCK_OFFSET],
							{BLOCK_OFFSET{1'b0}}};
						dcache2proc_response = mem_response;
					end
				end
			end
			default:
			begin
				read_enable = 1'b0;
			end
		endcase
	end

endmodule

/* verilog/dcache_mem.sv */
`timescale 1ns/10ps

module dcache_mem
(
	input  logic                                    clock,
	input  logic                                    reset,
	input  logic [mem_pkg::DCACHE_INDEX_BITS-1:0]   dcache_index,
	input  logic [mem_pkg::DCACHE_TAG_BITS-1:0]     dcache_tag,
	input  logic                                    read_enable,
	input  logic                                    write_enable,
	input  logic [mem_pkg::BLOCK_BITS-1:0]          write_data,
	input  mem_pkg::bus_command                     dmem_command,
	input  logic [mem_pkg::TAG_BITS-1:0]            dmem_response,
	input  logic [mem_pkg::TAG_BITS-1:0]            mem_tag,
	input  logic [mem_pkg::BLOCK_BITS-1:0]          mem_data,
	output logic [mem_pkg::BLOCK_BITS-1:0]          cachemem_data,
	output logic                                    cachemem_valid,
	output logic                                    cachemem_dirty,
	output logic                                    cachemem_miss,
	output logic                                    cachemem_full,
	output logic [mem_pkg::ADDR_BITS-1:0]           cachemem_victim_addr,
	output logic [mem_pkg::TAG_BITS-1:0]            fill_tag
);

	import mem_pkg::*;

	localparam int LINES = 2 ** DCACHE_INDEX_BITS;

	logic [BLOCK_BITS-1:0]        data [LINES];
	logic [DCACHE_TAG_BITS-1:0]   tags [LINES];
	logic [LINES-1:0]             valid;
	logic [LINES-1:0]             dirty;

	// miss table, one entry per outstanding fill
	logic [MSHR_ENTRIES-1:0]      mshr_valid;
	logic [TAG_BITS-1:0]          mshr_tag [MSHR_ENTRIES];
	logic [DCACHE_INDEX_BITS-1:0] mshr_index [MSHR_ENTRIES];

	logic                         fill_hit;
	logic [MSHR_SLOT_BITS-1:0]    fill_slot;
	logic [DCACHE_INDEX_BITS-1:0] fill_index;
	logic                         free_found;
	logic [MSHR_SLOT_BITS-1:0]    free_slot;
	logic                         index_pending;
	logic                         load_accepted;
	logic                         store_accepted;

	always_comb
	begin
		fill_hit      = 1'b0;
		fill_slot     = '0;
		fill_index    = '0;
		free_found    = 1'b0;
		free_slot     = '0;
		index_pending = 1'b0;
		for (int i = 0; i < MSHR_ENTRIES; i++)
		begin
			if (mshr_valid[i] && mem_tag != '0 && mshr_tag[i] == mem_tag)
			begin
				fill_hit   = 1'b1;
				fill_slot  = MSHR_SLOT_BITS'(i);
				fill_index = mshr_index[i];
			end
			if (mshr_valid[i] && mshr_index[i] == dcache_index)
				index_pending = 1'b1;
			if (!mshr_valid[i] && !free_found)
			begin
				free_found = 1'b1;
				free_slot  = MSHR_SLOT_BITS'(i);
			end
		end
	end

	assign load_accepted  = (dmem_command == bus_load) && (dmem_response != '0);
	assign store_accepted = (dmem_command == bus_store) && (dmem_response != '0);

	assign fill_tag = fill_hit ? mem_tag : '0;

	// fill data takes the read port on its return cycle
	assign cachemem_data  = fill_hit ? mem_data :
		(read_enable ? data[dcache_index] : '0);
	assign cachemem_valid = valid[dcache_index];
	assign cachemem_dirty = dirty[dcache_index];
	assign cachemem_miss  = !valid[dcache_index] || (tags[dcache_index] != dcache_tag);
	// a second miss to a pending line waits as well
	assign cachemem_full  = !free_found || index_pending;
	assign cachemem_victim_addr = {tags[dcache_index], dcache_index, {BLOCK_OFFSET{1'b0}}};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid      <= '0;
			dirty      <= '0;
			mshr_valid <= '0;
		end
		else
		begin
			if (write_enable)
				dirty[dcache_index] <= 1'b1;
			if (store_accepted)
			begin
				valid[dcache_index] <= 1'b0;
				dirty[dcache_index] <= 1'b0;
			end
			if (load_accepted)
			begin
				valid[dcache_index]   <= 1'b0;
				mshr_valid[free_slot] <= 1'b1;
			end
			if (fill_hit)
			begin
				valid[fill_index]     <= 1'b1;
				dirty[fill_index]     <= 1'b0;
				mshr_valid[fill_slot] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (write_enable)
			data[dcache_index] <= write_data;
		if (load_accepted)
		begin
			tags[dcache_index]    <= dcache_tag;
			mshr_tag[free_slot]   <= dmem_response;
			mshr_index[free_slot] <= dcache_index;
		end
		if (fill_hit)
			data[fill_index] <= mem_data;
	end

endmodule

/* verilog/icache.sv */
`timescale 1ns/10ps

module icache
(
	input  logic                            clock,
	input  logic                            reset,
	input  logic [mem_pkg::ADDR_BITS-1:0]   fetch_addr,
	input  logic                            fetch_enable,
	input  logic [mem_pkg::TAG_BITS-1:0]    imem_response,
	input  logic [mem_pkg::TAG_BITS-1:0]    mem_tag,
	input  logic [mem_pkg::BLOCK_BITS-1:0]  mem_data,
	output logic [mem_pkg::BLOCK_BITS-1:0]  fetch_data,
	output logic                            fetch_valid,
	output mem_pkg::bus_command             imem_command,
	output logic [mem_pkg::ADDR_BITS-1:0]   imem_addr
);

	import mem_pkg::*;

	localparam int LINES = 2 ** ICACHE_INDEX_BITS;

	logic [BLOCK_BITS-1:0]        data [LINES];
	logic [ICACHE_TAG_BITS-1:0]   tags [LINES];
	logic [LINES-1:0]             valid;

	logic [ICACHE_INDEX_BITS-1:0] fetch_index;
	logic [ICACHE_TAG_BITS-1:0]   fetch_tag;
	logic                         hit;

	// the single outstanding miss
	logic [TAG_BITS-1:0]          miss_tag;
	logic [ICACHE_INDEX_BITS-1:0] miss_index;
	logic [ICACHE_TAG_BITS-1:0]   miss_line_tag;
	logic                         fill;

	assign {fetch_tag, fetch_index} = fetch_addr[ADDR_BITS-1:BLOCK_OFFSET];

	assign hit         = valid[fetch_index] && (tags[fetch_index] == fetch_tag);
	assign fetch_valid = fetch_enable && hit;
	assign fetch_data  = data[fetch_index];

	// keep asking until the arbiter and memory take it
	assign imem_command = (fetch_enable && !hit && miss_tag == '0) ? bus_load : bus_none;
	assign imem_addr    = {fetch_addr[ADDR_BITS-1:BLOCK_OFFSET], {BLOCK_OFFSET{1'b0}}};

	assign fill = (miss_tag != '0) && (mem_tag == miss_tag);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid    <= '0;
			miss_tag <= '0;
		end
		else
		begin
			if (imem_command == bus_load && imem_response != '0)
				miss_tag <= imem_response;
			if (fill)
			begin
				valid[miss_index] <= 1'b1;
				miss_tag          <= '0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (imem_command == bus_load && imem_response != '0)
		begin
			miss_index    <= fetch_index;
			miss_line_tag <= fetch_tag;
		end
		if (fill)
		begin
			data[miss_index] <= mem_data;
			tags[miss_index] <= miss_line_tag;
		end
	end

endmodule

/* verilog/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter
(
	// dcache side, fixed priority
	input  mem_pkg::bus_command             dmem_command,
	input  logic [mem_pkg::ADDR_BITS-1:0]   dmem_addr,
	input  logic [mem_pkg::BLOCK_BITS-1:0]  dmem_data,

	// icache side, load only
	input  mem_pkg::bus_command             imem_command,
	input  logic [mem_pkg::ADDR_BITS-1:0]   imem_addr,

	// shared memory port
	input  logic [mem_pkg::TAG_BITS-1:0]    bus_response,
	output mem_pkg::bus_command             bus_command,
	output logic [mem_pkg::ADDR_BITS-1:0]   bus_addr,
	output logic [mem_pkg::BLOCK_BITS-1:0]  bus_data,
	output logic [mem_pkg::TAG_BITS-1:0]    dmem_response,
	output logic [mem_pkg::TAG_BITS-1:0]    imem_response
);

	import mem_pkg::*;

	logic dcache_grant;

	assign dcache_grant = (dmem_command != bus_none);

	assign bus_command = dcache_grant ? dmem_command : imem_command;
	assign bus_addr    = dcache_grant ? dmem_addr : imem_addr;
	assign bus_data    = dcache_grant ? dmem_data : '0;

	// a tag belongs to whichever side was granted, the other sees a refusal
	assign dmem_response = dcache_grant ? bus_response : '0;
	assign imem_response = dcache_grant ? '0 : bus_response;

endmodule

/* verilog/mem_model.sv */
`timescale 1ns/10ps

module mem_model
(
	input  logic                            clock,
	input  logic                            reset,
	input  mem_pkg::bus_command             bus_command,
	input  logic [mem_pkg::ADDR_BITS-1:0]   bus_addr,
	input  logic [mem_pkg::BLOCK_BITS-1:0]  bus_data,
	output logic [mem_pkg::TAG_BITS-1:0]    bus_response,
	output logic [mem_pkg::TAG_BITS-1:0]    mem_tag,
	output logic [mem_pkg::BLOCK_BITS-1:0]  mem_data
);

	import mem_pkg::*;

	localparam int TAGS = 2 ** TAG_BITS;

	logic [BLOCK_BITS-1:0]     mem [MEM_BLOCKS];

	// tag zero is never handed out
	logic [TAGS-1:1]           free_tags;
	logic [TAG_BITS-1:0]       new_tag;
	logic                      accept;
	logic [MEM_INDEX_BITS-1:0] block;

	// return pipeline, last stage is the broadcast
	logic [TAG_BITS-1:0]       pipe_tag [MEM_LATENCY];
	mem_pkg::bus_command       pipe_cmd [MEM_LATENCY];
	logic [MEM_INDEX_BITS-1:0] pipe_block [MEM_LATENCY];

	// block b holds {~b, b}
	initial
	begin
		for (int b = 0; b < MEM_BLOCKS; b++)
			mem[b] = {~32'(b), 32'(b)};
	end

	always_comb
	begin
		new_tag = '0;
		for (int t = TAGS - 1; t >= 1; t--)
		begin
			if (free_tags[t])
				new_tag = TAG_BITS'(t);
		end
	end

	assign block        = bus_addr[BLOCK_OFFSET +: MEM_INDEX_BITS];
	assign accept       = (bus_command != bus_none) && (new_tag != '0);
	assign bus_response = accept ? new_tag : '0;

	assign mem_tag  = pipe_tag[MEM_LATENCY-1];
	assign mem_data = (pipe_cmd[MEM_LATENCY-1] == bus_load) ?
		mem[pipe_block[MEM_LATENCY-1]] : '0;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			free_tags <= '1;
			pipe_tag  <= '{default: '0};
			pipe_cmd  <= '{default: bus_none};
		end
		else
		begin
			pipe_tag[0] <= bus_response;
			pipe_cmd[0] <= accept ? bus_command : bus_none;
			for (int s = 1; s < MEM_LATENCY; s++)
			begin
				pipe_tag[s] <= pipe_tag[s-1];
				pipe_cmd[s] <= pipe_cmd[s-1];
			end
			if (accept)
				free_tags[new_tag] <= 1'b0;
			if (mem_tag != '0)
				free_tags[mem_tag] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		pipe_block[0] <= block;
		for (int s = 1; s < MEM_LATENCY; s++)
			pipe_block[s] <= pipe_block[s-1];
		// stores land at acceptance, loads read on return
		if (accept && bus_command == bus_store)
			mem[block] <= bus_data;
	end

endmodule

/* verilog/mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top
(
	input  logic                            clock,
	input  logic                            reset,

	// processor load/store port
	input  mem_pkg::bus_command             proc2dcache_command,
	input  logic [mem_pkg::ADDR_BITS-1:0]   proc2dcache_addr,
	input  logic [mem_pkg::BLOCK_BITS-1:0]  proc2dcache_data,
	output logic [mem_pkg::BLOCK_BITS-1:0]  dcache_data_out,
	output logic                            dcache_data_hit,
	output logic [mem_pkg::TAG_BITS-1:0]    dcache2proc_response,
	output logic [mem_pkg::TAG_BITS-1:0]    dcache2proc_tag,

	// fetch port
	input  logic [mem_pkg::ADDR_BITS-1:0]   fetch_addr,
	input  logic                            fetch_enable,
	output logic [mem_pkg::BLOCK_BITS-1:0]  fetch_data,
	output logic                            fetch_valid
);

	import mem_pkg::*;

	// controller to arrays
	logic [DCACHE_INDEX_BITS-1:0] dcache_index;
	logic [DCACHE_TAG_BITS-1:0]   dcache_tag;
	logic                         read_enable;
	logic                         write_enable;
	logic [BLOCK_BITS-1:0]        write_data;
	logic [BLOCK_BITS-1:0]        cachemem_data;
	logic                         cachemem_valid;
	logic                         cachemem_dirty;
	logic                         cachemem_miss;
	logic                         cachemem_full;
	logic [ADDR_BITS-1:0]         cachemem_victim_addr;
	logic [TAG_BITS-1:0]          fill_tag;

	// cache requests
	bus_command                   dmem_command;
	logic [ADDR_BITS-1:0]         dmem_addr;
	logic [BLOCK_BITS-1:0]        dmem_data;
	logic [TAG_BITS-1:0]          dmem_response;
	bus_command                   imem_command;
	logic [ADDR_BITS-1:0]         imem_addr;
	logic [TAG_BITS-1:0]          imem_response;

	// memory port and broadcast
	bus_command                   mem_command;
	logic [ADDR_BITS-1:0]         bus_addr;
	logic [BLOCK_BITS-1:0]        bus_data;
	logic [TAG_BITS-1:0]          bus_response;
	logic [TAG_BITS-1:0]          mem_tag;
	logic [BLOCK_BITS-1:0]        mem_data;

	// controller sees only fills the arrays recognized
	dcache_controller u_dcache_controller
	(
		.proc2dcache_command  (proc2dcache_command),
		.proc2dcache_addr     (proc2dcache_addr),
		.proc2dcache_data     (proc2dcache_data),
		.mem_response         (dmem_response),
		.mem_tag              (fill_tag),
		.cachemem_data        (cachemem_data),
		.cachemem_valid       (cachemem_valid),
		.cachemem_dirty       (cachemem_dirty),
		.cachemem_miss        (cachemem_miss),
		.cachemem_full        (cachemem_full),
		.cachemem_victim_addr (cachemem_victim_addr),
		.dcache_index         (dcache_index),
		.dcache_tag           (dcache_tag),
		.read_enable          (read_enable),
		.write_enable         (write_enable),
		.write_data           (write_data),
		.dmem_command         (dmem_command),
		.dmem_addr            (dmem_addr),
		.dmem_data            (dmem_data),
		.dcache_data_out      (dcache_data_out),
		.dcache_data_hit      (dcache_data_hit),
		.dcache2proc_response (dcache2proc_response),
		.dcache2proc_tag      (dcache2proc_tag)
	);

	dcache_mem u_dcache_mem
	(
		.clock                (clock),
		.reset                (reset),
		.dcache_index         (dcache_index),
		.dcache_tag           (dcache_tag),
		.read_enable          (read_enable),
		.write_enable         (write_enable),
		.write_data           (write_data),
		.dmem_command         (dmem_command),
		.dmem_response        (dmem_response),
		.mem_tag              (mem_tag),
		.mem_data             (mem_data),
		.cachemem_data        (cachemem_data),
		.cachemem_valid       (cachemem_valid),
		.cachemem_dirty       (cachemem_dirty),
		.cachemem_miss        (cachemem_miss),
		.cachemem_full        (cachemem_full),
		.cachemem_victim_addr (cachemem_victim_addr),
		.fill_tag             (fill_tag)
	);

	icache u_icache
	(
		.clock         (clock),
		.reset         (reset),
		.fetch_addr    (fetch_addr),
		.fetch_enable  (fetch_enable),
		.imem_response (imem_response),
		.mem_tag       (mem_tag),
		.mem_data      (mem_data),
		.fetch_data    (fetch_data),
		.fetch_valid   (fetch_valid),
		.imem_command  (imem_command),
		.imem_addr     (imem_addr)
	);

	mem_arbiter u_mem_arbiter
	(
		.dmem_command  (dmem_command),
		.dmem_addr     (dmem_addr),
		.dmem_data     (dmem_data),
		.imem_command  (imem_command),
		.imem_addr     (imem_addr),
		.bus_response  (bus_response),
		.bus_command   (mem_command),
		.bus_addr      (bus_addr),
		.bus_data      (bus_data),
		.dmem_response (dmem_response),
		.imem_response (imem_response)
	);

	mem_model u_mem_model
	(
		.clock        (clock),
		.reset        (reset),
		.bus_command  (mem_command),
		.bus_addr     (bus_addr),
		.bus_data     (bus_data),
		.bus_response (bus_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data)
	);

endmodule

/* tests/mem_subsys_chk.sv */
`timescale 1ns/10ps

module mem_subsys_chk
(
	input  logic                            clock,
	input  logic                            reset,
	input  mem_pkg::bus_command             mem_command,
	input  logic                            dcache_data_hit,
	input  logic [mem_pkg::TAG_BITS-1:0]    dcache2proc_response,
	input  logic [mem_pkg::TAG_BITS-1:0]    dcache2proc_tag,
	input  logic                            fetch_valid
);

	import mem_pkg::*;

	// tags announced in the last MEM_LATENCY cycles
	logic [TAG_BITS-1:0] recent [MEM_LATENCY];
	logic                tag_seen_recently;

	bit bad_response;
	bit bad_tag;
	bit bad_reset;
	logic failed;

	assign failed = bad_response || bad_tag || bad_reset;

	always_ff @(posedge clock)
	begin
		recent[0] <= dcache2proc_tag;
		for (int s = 1; s < MEM_LATENCY; s++)
			recent[s] <= recent[s-1];
	end

	always_comb
	begin
		tag_seen_recently = 1'b0;
		for (int k = 0; k < MEM_LATENCY; k++)
		begin
			if (recent[k] == dcache2proc_tag)
				tag_seen_recently = 1'b1;
		end
	end

	// a tag offered to the processor comes from a load on the memory bus
	response_needs_command: assert property (@(posedge clock) disable iff (reset)
		(dcache2proc_response != '0) |-> (mem_command == bus_load))
	else
	begin
		bad_response = 1'b1;
		$error("response tag without a load on the memory bus");
	end

	tag_returns_once: assert property (@(posedge clock) disable iff (reset)
		(dcache2proc_tag != '0) |-> !tag_seen_recently)
	else
	begin
		bad_tag = 1'b1;
		$error("tag %0h announced twice within the memory latency", dcache2proc_tag);
	end

	// first edge of reset still clears the arrays
	quiet_in_reset: assert property (@(posedge clock)
		(reset && $past(reset)) |->
		(!dcache_data_hit && !fetch_valid && dcache2proc_response == '0 &&
		dcache2proc_tag == '0))
	else
	begin
		bad_reset = 1'b1;
		$error("outputs not idle during reset");
	end

endmodule

bind mem_subsys_top mem_subsys_chk u_chk
(
	.clock                (clock),
	.reset                (reset),
	.mem_command          (mem_command),
	.dcache_data_hit      (dcache_data_hit),
	.dcache2proc_response (dcache2proc_response),
	.dcache2proc_tag      (dcache2proc_tag),
	.fetch_valid          (fetch_valid)
);

/* tests/mem_subsys_tb.sv */
`timescale 1ns/10ps

module mem_subsys_tb;

	import mem_pkg::*;

	localparam int FETCHES  = 10;
	localparam int DLOADS   = 6;
	localparam int REQUESTS = 16 + FETCHES + DLOADS;

	logic                  clock;
	logic                  reset;
	bus_command            proc2dcache_command;
	logic [ADDR_BITS-1:0]  proc2dcache_addr;
	logic [BLOCK_BITS-1:0] proc2dcache_data;
	logic [BLOCK_BITS-1:0] dcache_data_out;
	logic                  dcache_data_hit;
	logic [TAG_BITS-1:0]   dcache2proc_response;
	logic [TAG_BITS-1:0]   dcache2proc_tag;
	logic [ADDR_BITS-1:0]  fetch_addr;
	logic                  fetch_enable;
	logic [BLOCK_BITS-1:0] fetch_data;
	logic                  fetch_valid;

	// architectural memory view, only blocks written by stores
	logic [BLOCK_BITS-1:0] stored [int];
	int                    seed;
	logic [ADDR_BITS-1:0]  burst_addr [5];
	logic [TAG_BITS-1:0]   burst_tag [5];
	logic                  burst_hit;
	logic [ADDR_BITS-1:0]  fetch_list [FETCHES];
	logic [ADDR_BITS-1:0]  dload_list [DLOADS];
	logic                  first_hit;
	logic [TAG_BITS-1:0]   first_tag;
	int                    seen;

	mem_subsys_top DUT (.*);

	function automatic int block_of(logic [ADDR_BITS-1:0] addr);
		return int'(addr[BLOCK_OFFSET +: MEM_INDEX_BITS]);
	endfunction

	// initial content is {~b, b} unless a store replaced it
	function automatic logic [BLOCK_BITS-1:0] expected_block(logic [ADDR_BITS-1:0] addr);
		int b;
		b = block_of(addr);
		if (stored.exists(b))
			return stored[b];
		return {~32'(b), 32'(b)};
	endfunction

	function automatic logic [ADDR_BITS-1:0] random_addr();
		logic [31:0] r;
		r = $random(seed);
		return ADDR_BITS'({r[MEM_INDEX_BITS-1:0], {BLOCK_OFFSET{1'b0}}});
	endfunction

	task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
		$display("mismatch in %s: expected %h, actual %h", name, expected, actual);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_failure(string what);
		$display("error: %s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	// ends on the posedge where the tag is broadcast
	task automatic wait_for_tag(logic [TAG_BITS-1:0] tag, output int cycles);
		cycles = 0;
		do
		begin
			@(posedge clock);
			cycles++;
		end
		while (dcache2proc_tag != tag);
	endtask

	task automatic load_block(string name, logic [ADDR_BITS-1:0] addr,
		output logic hit0, output logic [TAG_BITS-1:0] tag0);
		logic [BLOCK_BITS-1:0] exp;
		logic [TAG_BITS-1:0]   tag;
		int                    cycles;
		bit                    done;
		bit                    first;
		exp   = expected_block(addr);
		done  = 1'b0;
		first = 1'b1;
		while (!done)
		begin
			proc2dcache_command = bus_load;
			proc2dcache_addr    = addr;
			@(posedge clock);
			tag = dcache2proc_response;
			if (first)
			begin
				hit0  = dcache_data_hit;
				tag0  = tag;
				first = 1'b0;
			end
			if (dcache_data_hit)
			begin
				assert (dcache_data_out == exp) else report_mismatch(name, exp, dcache_data_out);
				done = 1'b1;
			end
			@(negedge clock);
			proc2dcache_command = bus_none;
			if (!done && tag != '0)
			begin
				wait_for_tag(tag, cycles);
				assert (cycles == MEM_LATENCY)
					else report_mismatch({name, " latency"}, 64'(MEM_LATENCY), 64'(cycles));
				assert (dcache_data_out == exp)
					else report_mismatch({name, " fill"}, exp, dcache_data_out);
				@(negedge clock);
			end
		end
	endtask

	task automatic store_block(logic [ADDR_BITS-1:0] addr, logic [BLOCK_BITS-1:0] data,
		output logic hit0);
		logic [TAG_BITS-1:0] tag;
		int                  cycles;
		bit                  done;
		bit                  first;
		done  = 1'b0;
		first = 1'b1;
		while (!done)
		begin
			proc2dcache_command = bus_store;
			proc2dcache_addr    = addr;
			proc2dcache_data    = data;
			@(posedge clock);
			tag = dcache2proc_response;
			if (first)
			begin
				hit0  = dcache_data_hit;
				first = 1'b0;
			end
			done = dcache_data_hit;
			@(negedge clock);
			proc2dcache_command = bus_none;
			if (!done && tag != '0)
			begin
				wait_for_tag(tag, cycles);
				@(negedge clock);
			end
		end
		stored[block_of(addr)] = data;
	endtask

	task automatic fetch_block(string name, logic [ADDR_BITS-1:0] addr);
		logic [BLOCK_BITS-1:0] exp;
		exp          = expected_block(addr);
		fetch_enable = 1'b1;
		fetch_addr   = addr;
		@(posedge clock);
		while (!fetch_valid)
			@(posedge clock);
		assert (fetch_data == exp) else report_mismatch(name, exp, fetch_data);
		@(negedge clock);
		fetch_enable = 1'b0;
	endtask

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	// ends the run if a request never completes
	initial
	begin
		repeat (10 + REQUESTS * (MEM_LATENCY + 20))
			@(posedge clock);
		$display("error: run did not finish within the cycle budget");
		$display("Checks failed");
		$fatal(1);
	end

	always @(negedge clock)
	begin
		if (DUT.u_chk.failed)
		begin
			$display("error: an assertion bound to the DUT failed");
			$display("Checks failed");
			$fatal(1);
		end
	end

	initial
	begin
		seed                = 32'h4004f2d7;
		reset               = 1'b1;
		proc2dcache_command = bus_none;
		proc2dcache_addr    = '0;
		proc2dcache_data    = '0;
		fetch_addr          = '0;
		fetch_enable        = 1'b0;
		repeat (10)
			@(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		@(posedge clock);
		assert ({dcache_data_hit, fetch_valid, dcache2proc_response, dcache2proc_tag} == '0)
			else report_mismatch("after reset", 64'd0, 64'({dcache_data_hit, fetch_valid,
			dcache2proc_response, dcache2proc_tag}));
		@(negedge clock);

		load_block("load miss", 64'h80, first_hit, first_tag);
		assert (!first_hit && first_tag != '0)
			else report_failure("first load of a block did not start a miss");
		load_block("repeat load", 64'h80, first_hit, first_tag);
		assert (first_hit) else report_failure("repeat load did not hit");

		store_block(64'h80, 64'h0123_4567_89ab_cdef, first_hit);
		assert (first_hit) else report_failure("store to a resident block did not hit");
		load_block("load after store", 64'h80, first_hit, first_tag);
		assert (first_hit) else report_failure("load after store hit did not hit");

		// 0x100 and 0x200 share dcache index 0
		store_block(64'h100, 64'hfeed_f00d_5555_aaaa, first_hit);
		load_block("evicting load", 64'h200, first_hit, first_tag);
		assert (!first_hit && first_tag == '0)
			else report_failure("load over a dirty line completed or started a fill");
		load_block("load of written back block", 64'h100, first_hit, first_tag);

		for (int i = 0; i < 5; i++)
		begin
			burst_addr[i]       = 64'h1000 + 64'(i * 8);
			proc2dcache_command = bus_load;
			proc2dcache_addr    = burst_addr[i];
			@(posedge clock);
			burst_tag[i] = dcache2proc_response;
			burst_hit    = dcache_data_hit;
			@(negedge clock);
			if (i < 4)
				assert (burst_tag[i] != '0) else report_failure("burst miss was refused");
		end
		proc2dcache_command = bus_none;
		assert (burst_tag[4] == '0 && !burst_hit)
			else report_failure("fifth miss accepted with a full miss table");
		seen = 0;
		while (seen < 4)
		begin
			@(posedge clock);
			for (int i = 0; i < 4; i++)
			begin
				if (dcache2proc_tag != '0 && dcache2proc_tag == burst_tag[i])
				begin
					assert (dcache_data_out == expected_block(burst_addr[i]))
						else report_mismatch("burst fill", expected_block(burst_addr[i]),
						dcache_data_out);
					seen++;
				end
			end
		end
		@(negedge clock);
		load_block("miss table retry", burst_addr[4], first_hit, first_tag);

		// push the dirty line at 0x80 out to memory
		load_block("writeback of 0x80", 64'h180, first_hit, first_tag);

		for (int i = 0; i < FETCHES; i++)
			fetch_list[i] = random_addr();
		for (int i = 0; i < DLOADS; i++)
			dload_list[i] = random_addr();
		fork
			begin
				fetch_block("fetch of stored block", 64'h80);
				fetch_block("fetch of written back block", 64'h100);
				for (int i = 0; i < FETCHES; i++)
					fetch_block("random fetch", fetch_list[i]);
			end
			begin
				for (int i = 0; i < DLOADS; i++)
					load_block("shared port load", dload_list[i], first_hit, first_tag);
			end
		join

		repeat (MEM_LATENCY + 2)
			@(posedge clock);
		if (!DUT.u_chk.failed)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Checks failed");
			$fatal(1);
		end
	end

endmodule

/* tb.f */
verilog/mem_pkg.sv
verilog/dcache_controller.sv
verilog/dcache_mem.sv
verilog/icache.sv
verilog/mem_arbiter.sv
verilog/mem_model.sv
verilog/mem_subsys_top.sv
tests/mem_subsys_chk.sv
tests/mem_subsys_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = mem_subsys_tb
FILELIST   = tb.f
OBJ_DIR    = obj_dir
SIM_ARGS   = +verilator+error+limit+100
PASS_TEXT  = All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
